// ==== design/updi_pkg.sv ====
// shared UPDI opcodes, addresses, key, widths and result codes; imported by every RTL module
package updi_pkg;

	// instructions the sequencer can issue
	typedef enum logic [2:0] {
		INSTR_LDCS,
		INSTR_STCS,
		INSTR_KEY,
		INSTR_ST,
		INSTR_LD,
		INSTR_REPEAT
	} updi_instr_t;

	// opcode base bytes, low nibble filled in by the framer
	localparam logic [7:0] OP_LD     = 8'h20;
	localparam logic [7:0] OP_ST     = 8'h60;
	localparam logic [7:0] OP_LDCS   = 8'h80;
	localparam logic [7:0] OP_REPEAT = 8'hA0;
	localparam logic [7:0] OP_STCS   = 8'hC0;
	localparam logic [7:0] OP_KEY    = 8'hE0;

	localparam logic [7:0] UPDI_SYNC = 8'h55;
	localparam logic [7:0] UPDI_ACK  = 8'h40;

	// control/status space
	localparam logic [3:0] CS_STATUSA    = 4'h0;
	localparam logic [3:0] CS_KEY_STATUS = 4'h7;
	localparam logic [3:0] CS_RESET_REQ  = 4'h8;
	localparam logic [3:0] CS_SYS_STATUS = 4'hB;

	// NVMPROG key accepted, and NVM programming mode entered
	localparam int KEY_STATUS_NVMPROG_BIT = 4;
	localparam int SYS_STATUS_NVMPROG_BIT = 3;

	localparam logic [7:0] RESET_SIGNATURE = 8'h59;

	// signature row base, device ID sits in the first three bytes
	localparam logic [15:0] SIGROW_ADDR = 16'h1100;

	// "NVMProg " with the first character in the top byte;
	// the low byte goes out on the wire first
	localparam logic [63:0] KEY_NVMPROG = 64'h4E56_4D50_726F_6720;

	// pointer modes for LD/ST
	localparam logic [1:0] PTR_INC = 2'b01;
	localparam logic [1:0] PTR_REG = 2'b10;

	// address/data size codes
	localparam logic [1:0] SIZE_BYTE = 2'b00;
	localparam logic [1:0] SIZE_WORD = 2'b01;

	localparam int MAX_DATA_BYTES = 8;
	localparam int DATA_IDX_W     = $clog2(MAX_DATA_BYTES);
	localparam int DATA_LEN_W     = DATA_IDX_W + 1;
	localparam int RX_COUNT_W     = 2;
	localparam int DEVICE_ID_W    = 24;

	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_STATUS_ZERO,
		ERR_KEY_REJECTED,
		ERR_PROG_TIMEOUT,
		ERR_LINK_FAILED
	} prog_error_t;

endpackage

// ==== design/updi_tx_framer.sv ====
// writes one UPDI frame (SYNC, opcode, data) into the UART TX FIFO and stalls on requested ACKs
`timescale 1ns/100ps

module updi_tx_framer import updi_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      link_abort,
	input  logic                      cmd_start,
	input  updi_instr_t               instr,
	input  logic [3:0]                cs_addr,
	input  logic [1:0]                ptr_mode,
	input  logic [1:0]                size_a,
	input  logic [7:0]                data [MAX_DATA_BYTES],
	input  logic [DATA_LEN_W-1:0]     data_len,
	input  logic [MAX_DATA_BYTES-1:0] ack_after,
	output logic                      cmd_done,
	output logic [7:0]                tx_data,
	output logic                      tx_wr_en,
	input  logic                      tx_full,
	output logic                      ack_expect,
	input  logic                      ack_ok
);

	typedef enum logic [2:0] {F_IDLE, F_SYNC, F_OPCODE, F_DATA, F_ACK} fstate_t;

	fstate_t                   state;
	logic [7:0]                opcode;
	logic [7:0]                opcode_q;
	logic [7:0]                data_q [MAX_DATA_BYTES];
	logic [DATA_LEN_W-1:0]     len_q;
	logic [MAX_DATA_BYTES-1:0] ack_q;
	logic [DATA_IDX_W-1:0]     idx;
	logic                      accept;
	logic                      last;

	always_comb begin
		case (instr)
			INSTR_LD:     opcode = OP_LD | {4'h0, ptr_mode, size_a};
			INSTR_ST:     opcode = OP_ST | {4'h0, ptr_mode, size_a};
			INSTR_LDCS:   opcode = OP_LDCS | {4'h0, cs_addr};
			INSTR_STCS:   opcode = OP_STCS | {4'h0, cs_addr};
			INSTR_REPEAT: opcode = OP_REPEAT;
			default:      opcode = OP_KEY;
		endcase
	end

	assign tx_wr_en = (state == F_SYNC) || (state == F_OPCODE) || (state == F_DATA);
	assign accept   = tx_wr_en && !tx_full;
	assign last     = (DATA_LEN_W'(idx) + DATA_LEN_W'(1) == len_q);

	always_comb begin
		case (state)
			F_SYNC:   tx_data = UPDI_SYNC;
			F_OPCODE: tx_data = opcode_q;
			default:  tx_data = data_q[idx];
		endcase
	end

	always_ff @(posedge clk) begin
		if (cmd_start && state == F_IDLE) begin
			opcode_q <= opcode;
			data_q   <= data;
			len_q    <= data_len;
			ack_q    <= ack_after;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || link_abort) begin
			state      <= F_IDLE;
			idx        <= '0;
			cmd_done   <= 1'b0;
			ack_expect <= 1'b0;
		end else begin
			cmd_done   <= 1'b0;
			ack_expect <= 1'b0;
			case (state)
				F_IDLE: begin
					idx <= '0;
					if (cmd_start) begin
						state <= F_SYNC;
					end
				end
				F_SYNC: begin
					if (accept) begin
						state <= F_OPCODE;
					end
				end
				F_OPCODE: begin
					if (accept && len_q == '0) begin
						cmd_done <= 1'b1;
						state    <= F_IDLE;
					end else if (accept) begin
						state <= F_DATA;
					end
				end
				F_DATA: begin
					if (accept && ack_q[idx]) begin
						ack_expect <= 1'b1;
						state      <= F_ACK;
					end else if (accept && last) begin
						cmd_done <= 1'b1;
						state    <= F_IDLE;
					end else if (accept) begin
						idx <= idx + DATA_IDX_W'(1);
					end
				end
				default: begin
					// idx still points at the byte that asked for the ACK
					if (ack_ok && last) begin
						cmd_done <= 1'b1;
						state    <= F_IDLE;
					end else if (ack_ok) begin
						idx   <= idx + DATA_IDX_W'(1);
						state <= F_DATA;
					end
				end
			endcase
		end
	end

endmodule

// ==== design/updi_rx_collector.sv ====
// pops reply bytes or a single ACK from the UART RX FIFO, with an idle timeout while waiting
`timescale 1ns/100ps

module updi_rx_collector import updi_pkg::*; #(
	parameter int TIMEOUT_CLKS = 100
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  link_abort,
	input  logic                  rx_start,
	input  logic [RX_COUNT_W-1:0] rx_count,
	input  logic                  ack_expect,
	input  logic [7:0]            rx_data,
	output logic                  rx_rd_en,
	input  logic                  rx_empty,
	output logic                  rx_valid,
	output logic [7:0]            rx_byte,
	output logic                  rx_done,
	output logic                  ack_ok,
	output logic                  ack_error,
	output logic                  rx_timeout
);

	localparam int TMO_W = $clog2(TIMEOUT_CLKS + 1);

	typedef enum logic [1:0] {C_IDLE, C_DATA, C_ACK} cstate_t;

	cstate_t               state;
	logic [RX_COUNT_W-1:0] remaining;
	logic [TMO_W-1:0]      idle_cnt;
	logic                  take;

	// the pop lands a cycle later, so skip the head byte while it is being removed
	assign take = (state != C_IDLE) && !rx_empty && !rx_rd_en;

	always_ff @(posedge clk) begin
		if (take) begin
			rx_byte <= rx_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || link_abort) begin
			state      <= C_IDLE;
			remaining  <= '0;
			idle_cnt   <= '0;
			rx_rd_en   <= 1'b0;
			rx_valid   <= 1'b0;
			rx_done    <= 1'b0;
			ack_ok     <= 1'b0;
			ack_error  <= 1'b0;
			rx_timeout <= 1'b0;
		end else begin
			rx_rd_en   <= take;
			rx_valid   <= take && state == C_DATA;
			rx_done    <= take && state == C_DATA && remaining == RX_COUNT_W'(1);
			ack_ok     <= take && state == C_ACK && rx_data == UPDI_ACK;
			ack_error  <= take && state == C_ACK && rx_data != UPDI_ACK;
			rx_timeout <= 1'b0;
			if (state == C_IDLE) begin
				idle_cnt  <= '0;
				remaining <= rx_count;
				if (rx_start) begin
					state <= C_DATA;
				end else if (ack_expect) begin
					state <= C_ACK;
				end
			end else if (take) begin
				idle_cnt  <= '0;
				remaining <= remaining - RX_COUNT_W'(1);
				if (state == C_ACK || remaining == RX_COUNT_W'(1)) begin
					state <= C_IDLE;
				end
			end else if (idle_cnt == TMO_W'(TIMEOUT_CLKS - 1)) begin
				rx_timeout <= 1'b1;
				state      <= C_IDLE;
			end else begin
				idle_cnt <= idle_cnt + TMO_W'(1);
			end
		end
	end

endmodule

// ==== design/prog_sequencer.sv ====
// programming FSM that walks UPDI bring-up, NVMPROG entry and the device ID read, one frame at a time
`timescale 1ns/100ps

module prog_sequencer import updi_pkg::*; #(
	parameter int DELAY_CLKS  = 100,
	parameter int POLL_LIMIT  = 4,
	parameter int RETRY_LIMIT = 3
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	output logic                      busy,
	output logic                      double_break_start,
	input  logic                      double_break_done,
	output logic                      cmd_start,
	output updi_instr_t               instr,
	output logic [3:0]                cs_addr,
	output logic [1:0]                ptr_mode,
	output logic [1:0]                size_a,
	output logic [7:0]                data [MAX_DATA_BYTES],
	output logic [DATA_LEN_W-1:0]     data_len,
	output logic [MAX_DATA_BYTES-1:0] ack_after,
	input  logic                      cmd_done,
	output logic                      rx_start,
	output logic [RX_COUNT_W-1:0]     rx_count,
	input  logic                      rx_valid,
	input  logic [7:0]                rx_byte,
	input  logic                      rx_done,
	input  logic                      link_abort,
	output logic [DEVICE_ID_W-1:0]    device_id,
	output logic                      id_valid,
	output prog_error_t               error_code
);

	localparam int DELAY_W = $clog2(DELAY_CLKS + 1);
	localparam int POLL_W  = $clog2(POLL_LIMIT + 1);
	localparam int RETRY_W = $clog2(RETRY_LIMIT + 1);

	typedef enum logic [2:0] {
		S_IDLE, S_BREAK, S_BREAK_WAIT, S_ISSUE, S_WAIT_TX, S_WAIT_RX, S_NEXT, S_DELAY
	} state_t;

	typedef enum logic [3:0] {
		STEP_STATUSA, STEP_KEY, STEP_KEY_STATUS, STEP_RESET_SET, STEP_RESET_CLR,
		STEP_SYS_STATUS, STEP_PTR, STEP_REPEAT, STEP_LD
	} step_t;

	state_t                 state;
	step_t                  step;
	logic [DELAY_W-1:0]     delay_cnt;
	logic [POLL_W-1:0]      poll_cnt;
	logic [RETRY_W-1:0]     retry_cnt;
	logic [DEVICE_ID_W-1:0] result;
	logic [7:0]             last_byte;

	assign last_byte          = result[7:0];
	assign busy               = (state != S_IDLE);
	assign double_break_start = (state == S_BREAK);
	assign cmd_start          = (state == S_ISSUE);

	// frame contents for the current step, latched by the framer on cmd_start
	always_comb begin
		instr     = INSTR_LDCS;
		cs_addr   = CS_STATUSA;
		ptr_mode  = 2'b00;
		size_a    = SIZE_BYTE;
		data      = '{default: 8'h00};
		data_len  = '0;
		ack_after = '0;
		rx_count  = '0;
		case (step)
			STEP_STATUSA: begin
				rx_count = RX_COUNT_W'(1);
			end
			STEP_KEY: begin
				instr    = INSTR_KEY;
				data_len = DATA_LEN_W'(MAX_DATA_BYTES);
				for (int i = 0; i < MAX_DATA_BYTES; i++) begin
					data[i] = KEY_NVMPROG[8*i +: 8];
				end
			end
			STEP_KEY_STATUS: begin
				cs_addr  = CS_KEY_STATUS;
				rx_count = RX_COUNT_W'(1);
			end
			STEP_RESET_SET, STEP_RESET_CLR: begin
				instr    = INSTR_STCS;
				cs_addr  = CS_RESET_REQ;
				data[0]  = (step == STEP_RESET_SET) ? RESET_SIGNATURE : 8'h00;
				data_len = DATA_LEN_W'(1);
			end
			STEP_SYS_STATUS: begin
				cs_addr  = CS_SYS_STATUS;
				rx_count = RX_COUNT_W'(1);
			end
			STEP_PTR: begin
				// word address, target acks once both bytes are in
				instr        = INSTR_ST;
				ptr_mode     = PTR_REG;
				size_a       = SIZE_WORD;
				data[0]      = SIGROW_ADDR[7:0];
				data[1]      = SIGROW_ADDR[15:8];
				data_len     = DATA_LEN_W'(2);
				ack_after[1] = 1'b1;
			end
			STEP_REPEAT: begin
				instr    = INSTR_REPEAT;
				data[0]  = 8'd2;
				data_len = DATA_LEN_W'(1);
			end
			STEP_LD: begin
				instr    = INSTR_LD;
				ptr_mode = PTR_INC;
				rx_count = RX_COUNT_W'(3);
			end
			default: begin
				instr = INSTR_LDCS;
			end
		endcase
	end

	// received bytes shift in from the right, so the first ID byte ends up on top
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			result <= {result[DEVICE_ID_W-9:0], rx_byte};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= S_IDLE;
			step       <= STEP_STATUSA;
			rx_start   <= 1'b0;
			delay_cnt  <= '0;
			poll_cnt   <= '0;
			retry_cnt  <= '0;
			device_id  <= '0;
			id_valid   <= 1'b0;
			error_code <= ERR_NONE;
		end else begin
			rx_start <= 1'b0;
			if (link_abort && state != S_IDLE) begin
				if (retry_cnt == RETRY_W'(RETRY_LIMIT)) begin
					error_code <= ERR_LINK_FAILED;
					state      <= S_IDLE;
				end else begin
					retry_cnt <= retry_cnt + RETRY_W'(1);
					state     <= S_BREAK;
				end
			end else begin
				case (state)
					S_IDLE: begin
						if (start) begin
							id_valid   <= 1'b0;
							error_code <= ERR_NONE;
							retry_cnt  <= '0;
							state      <= S_BREAK;
						end
					end
					S_BREAK: begin
						step     <= STEP_STATUSA;
						poll_cnt <= '0;
						state    <= S_BREAK_WAIT;
					end
					S_BREAK_WAIT: begin
						if (double_break_done) begin
							state <= S_ISSUE;
						end
					end
					S_ISSUE: begin
						state <= S_WAIT_TX;
					end
					S_WAIT_TX: begin
						// replies wait in the RX FIFO until the collector is armed
						if (cmd_done && rx_count != '0) begin
							rx_start <= 1'b1;
							state    <= S_WAIT_RX;
						end else if (cmd_done) begin
							state <= S_NEXT;
						end
					end
					S_WAIT_RX: begin
						if (rx_done) begin
							state <= S_NEXT;
						end
					end
					S_DELAY: begin
						if (delay_cnt == DELAY_W'(DELAY_CLKS - 1)) begin
							state <= S_ISSUE;
						end else begin
							delay_cnt <= delay_cnt + DELAY_W'(1);
						end
					end
					S_NEXT: begin
						state     <= S_ISSUE;
						delay_cnt <= '0;
						case (step)
							STEP_STATUSA: begin
								if (last_byte == 8'h00) begin
									error_code <= ERR_STATUS_ZERO;
									state      <= S_IDLE;
								end else begin
									step <= STEP_KEY;
								end
							end
							STEP_KEY: begin
								step <= STEP_KEY_STATUS;
							end
							STEP_KEY_STATUS: begin
								if (!last_byte[KEY_STATUS_NVMPROG_BIT]) begin
									error_code <= ERR_KEY_REJECTED;
									state      <= S_IDLE;
								end else begin
									step <= STEP_RESET_SET;
								end
							end
							STEP_RESET_SET: begin
								// hold the target in reset for the delay
								step  <= STEP_RESET_CLR;
								state <= S_DELAY;
							end
							STEP_RESET_CLR: begin
								step <= STEP_SYS_STATUS;
							end
							STEP_SYS_STATUS: begin
								if (last_byte[SYS_STATUS_NVMPROG_BIT]) begin
									step <= STEP_PTR;
								end else if (poll_cnt == POLL_W'(POLL_LIMIT - 1)) begin
									error_code <= ERR_PROG_TIMEOUT;
									state      <= S_IDLE;
								end else begin
									poll_cnt <= poll_cnt + POLL_W'(1);
									state    <= S_DELAY;
								end
							end
							STEP_PTR: begin
								step <= STEP_REPEAT;
							end
							STEP_REPEAT: begin
								step <= STEP_LD;
							end
							default: begin
								device_id <= result;
								id_valid  <= 1'b1;
								state     <= S_IDLE;
							end
						endcase
					end
					default: begin
						state <= S_IDLE;
					end
				endcase
			end
		end
	end

endmodule

// ==== design/updi_programmer.sv ====
// UPDI programming sequencer top level; connect to an external UART link with TX/RX FIFOs
`timescale 1ns/100ps

module updi_programmer import updi_pkg::*; #(
	parameter int DELAY_CLKS   = 100,
	parameter int TIMEOUT_CLKS = 100,
	parameter int POLL_LIMIT   = 4,
	parameter int RETRY_LIMIT  = 3
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	output logic                   busy,
	input  logic                   phy_error,
	output logic [7:0]             tx_data,
	output logic                   tx_wr_en,
	input  logic                   tx_full,
	input  logic [7:0]             rx_data,
	output logic                   rx_rd_en,
	input  logic                   rx_empty,
	output logic                   double_break_start,
	input  logic                   double_break_done,
	output logic [DEVICE_ID_W-1:0] device_id,
	output logic                   id_valid,
	output prog_error_t            error_code
);

	logic                      cmd_start;
	logic                      cmd_done;
	updi_instr_t               instr;
	logic [3:0]                cs_addr;
	logic [1:0]                ptr_mode;
	logic [1:0]                size_a;
	logic [7:0]                data [MAX_DATA_BYTES];
	logic [DATA_LEN_W-1:0]     data_len;
	logic [MAX_DATA_BYTES-1:0] ack_after;
	logic                      ack_expect;
	logic                      ack_ok;
	logic                      ack_error;
	logic                      rx_start;
	logic [RX_COUNT_W-1:0]     rx_count;
	logic                      rx_valid;
	logic [7:0]                rx_byte;
	logic                      rx_done;
	logic                      rx_timeout;
	logic                      link_abort;

	// any link fault flushes the framer and collector and restarts the run
	assign link_abort = phy_error | ack_error | rx_timeout;

	prog_sequencer #(
		.DELAY_CLKS(DELAY_CLKS),
		.POLL_LIMIT(POLL_LIMIT),
		.RETRY_LIMIT(RETRY_LIMIT)
	) i_prog_sequencer (
		.clk(clk), .rst(rst), .start(start), .busy(busy),
		.double_break_start(double_break_start), .double_break_done(double_break_done),
		.cmd_start(cmd_start), .instr(instr), .cs_addr(cs_addr), .ptr_mode(ptr_mode),
		.size_a(size_a), .data(data), .data_len(data_len), .ack_after(ack_after),
		.cmd_done(cmd_done), .rx_start(rx_start), .rx_count(rx_count),
		.rx_valid(rx_valid), .rx_byte(rx_byte), .rx_done(rx_done),
		.link_abort(link_abort), .device_id(device_id), .id_valid(id_valid),
		.error_code(error_code)
	);

	updi_tx_framer i_updi_tx_framer (
		.clk(clk), .rst(rst), .link_abort(link_abort), .cmd_start(cmd_start),
		.instr(instr), .cs_addr(cs_addr), .ptr_mode(ptr_mode), .size_a(size_a),
		.data(data), .data_len(data_len), .ack_after(ack_after), .cmd_done(cmd_done),
		.tx_data(tx_data), .tx_wr_en(tx_wr_en), .tx_full(tx_full),
		.ack_expect(ack_expect), .ack_ok(ack_ok)
	);

	updi_rx_collector #(
		.TIMEOUT_CLKS(TIMEOUT_CLKS)
	) i_updi_rx_collector (
		.clk(clk), .rst(rst), .link_abort(link_abort), .rx_start(rx_start),
		.rx_count(rx_count), .ack_expect(ack_expect), .rx_data(rx_data),
		.rx_rd_en(rx_rd_en), .rx_empty(rx_empty), .rx_valid(rx_valid),
		.rx_byte(rx_byte), .rx_done(rx_done), .ack_ok(ack_ok),
		.ack_error(ack_error), .rx_timeout(rx_timeout)
	);

endmodule

// ==== bench/updi_device_model.sv ====
// byte-level UPDI target for the testbench; decodes TX frames, queues replies and adds TX back-pressure
`timescale 1ns/100ps

module updi_device_model #(
	parameter int SEED = 85
) (
	input  logic        clk,
	input  logic        clear,
	input  logic [7:0]  statusa,
	input  logic [7:0]  key_status,
	input  logic [7:0]  not_ready_polls,
	input  logic [23:0] id_bytes,
	input  logic [7:0]  silent_attempts,
	input  logic [7:0]  tx_data,
	input  logic        tx_wr_en,
	output logic        tx_full,
	output logic [7:0]  rx_data,
	input  logic        rx_rd_en,
	output logic        rx_empty,
	input  logic        double_break_start,
	output logic        double_break_done,
	output logic [7:0]  break_cnt,
	output logic [7:0]  sys_read_cnt
);

	logic [7:0]  rx_fifo [$];
	logic [1:0]  dec_state;
	logic [7:0]  opcode;
	logic [3:0]  data_left;
	logic [7:0]  silent_left;
	logic [2:0]  break_wait;
	logic        s_clear;
	logic        s_write;
	logic        s_pop;
	logic        s_break;
	logic [7:0]  s_byte;

	// data bytes that follow each opcode byte
	function automatic logic [3:0] frame_data_len(input logic [7:0] op);
		case (op)
			8'hE0:   return 4'd8;
			8'hC8:   return 4'd1;
			8'h69:   return 4'd2;
			8'hA0:   return 4'd1;
			default: return 4'd0;
		endcase
	endfunction

	// a complete frame has arrived, queue whatever the target answers
	task automatic end_frame();
		case (opcode)
			8'h80: begin
				// a silent attempt swallows STATUSA so the host times out
				if (silent_left != 8'd0) begin
					silent_left = silent_left - 8'd1;
				end else begin
					rx_fifo.push_back(statusa);
				end
			end
			8'h87: begin
				rx_fifo.push_back(key_status);
			end
			8'h8B: begin
				rx_fifo.push_back((sys_read_cnt >= not_ready_polls) ? 8'h08 : 8'h31);
				sys_read_cnt = sys_read_cnt + 8'd1;
			end
			8'h69: begin
				rx_fifo.push_back(8'h40);
			end
			8'h24: begin
				rx_fifo.push_back(id_bytes[23:16]);
				rx_fifo.push_back(id_bytes[15:8]);
				rx_fifo.push_back(id_bytes[7:0]);
			end
			default: begin
			end
		endcase
		dec_state = 2'd0;
	endtask

	// decoder states: 0 waits for SYNC, 1 for the opcode, 2 counts data bytes
	task automatic take_byte(input logic [7:0] b);
		case (dec_state)
			2'd0: begin
				if (b == 8'h55) begin
					dec_state = 2'd1;
				end
			end
			2'd1: begin
				opcode    = b;
				data_left = frame_data_len(b);
				if (data_left == 4'd0) begin
					end_frame();
				end else begin
					dec_state = 2'd2;
				end
			end
			default: begin
				data_left = data_left - 4'd1;
				if (data_left == 4'd0) begin
					end_frame();
				end
			end
		endcase
	endtask

	initial begin
		void'($urandom(SEED));
		tx_full           = 1'b0;
		rx_data           = 8'h00;
		rx_empty          = 1'b1;
		double_break_done = 1'b0;
		break_cnt         = 8'd0;
		sys_read_cnt      = 8'd0;
		silent_left       = 8'd0;
		dec_state         = 2'd0;
		opcode            = 8'h00;
		data_left         = 4'd0;
		break_wait        = 3'd0;
		forever begin
			// what the DUT will see at the coming edge
			@(negedge clk);
			s_clear = clear;
			s_write = tx_wr_en && !tx_full;
			s_byte  = tx_data;
			s_pop   = rx_rd_en && !rx_empty;
			s_break = double_break_start;
			@(posedge clk);
			#1;
			if (s_pop && rx_fifo.size() != 0) begin
				rx_fifo.delete(0);
			end
			if (s_write) begin
				take_byte(s_byte);
			end
			double_break_done = 1'b0;
			if (break_wait != 3'd0) begin
				break_wait = break_wait - 3'd1;
				if (break_wait == 3'd0) begin
					double_break_done = 1'b1;
				end
			end
			if (s_break) begin
				break_cnt  = break_cnt + 8'd1;
				break_wait = 3'd3;
				dec_state  = 2'd0;
				rx_fifo.delete();
			end
			if (s_clear) begin
				rx_fifo.delete();
				dec_state    = 2'd0;
				break_wait   = 3'd0;
				break_cnt    = 8'd0;
				sys_read_cnt = 8'd0;
				silent_left  = silent_attempts;
			end
			tx_full  = ($urandom % 32'd4) == 32'd0;
			rx_empty = (rx_fifo.size() == 0);
			rx_data  = rx_empty ? 8'h00 : rx_fifo[0];
		end
	end

endmodule

// ==== bench/tb_updi_programmer.sv ====
// testbench for the UPDI programmer; runs every line of the test table against a byte-level target
`timescale 1ns/100ps

module tb_updi_programmer;

	localparam int DELAY_CLKS   = 20;
	localparam int TIMEOUT_CLKS = 30;
	localparam int POLL_LIMIT   = 4;
	localparam int RETRY_LIMIT  = 3;
	localparam int MAX_TESTS    = 16;
	localparam int REC_W        = 8;
	// one attempt at worst: all delays, one receive timeout, every frame under back-pressure
	localparam int RUN_CLKS = DELAY_CLKS * POLL_LIMIT + TIMEOUT_CLKS + 32 * (POLL_LIMIT + 8);

	logic        clk;
	logic        rst;
	logic        start;
	logic        busy;
	logic        phy_error;
	logic [7:0]  tx_data;
	logic        tx_wr_en;
	logic        tx_full;
	logic [7:0]  rx_data;
	logic        rx_rd_en;
	logic        rx_empty;
	logic        double_break_start;
	logic        double_break_done;
	logic [23:0] device_id;
	logic        id_valid;
	logic [2:0]  error_code;
	logic        model_clear;
	logic [7:0]  cfg_statusa;
	logic [7:0]  cfg_key_status;
	logic [7:0]  cfg_not_ready;
	logic [23:0] cfg_id;
	logic [7:0]  cfg_silent;
	logic [7:0]  break_cnt;
	logic [7:0]  sys_read_cnt;
	logic [7:0]  tests_mem [0:MAX_TESTS*REC_W];
	logic [7:0]  tx_seen [$];
	logic [7:0]  exp_tx [$];
	int          n_tests;
	int          cycle_cnt;
	int          cycle_limit;

	updi_programmer #(
		.DELAY_CLKS(DELAY_CLKS),
		.TIMEOUT_CLKS(TIMEOUT_CLKS),
		.POLL_LIMIT(POLL_LIMIT),
		.RETRY_LIMIT(RETRY_LIMIT)
	) i_updi_programmer (
		.clk(clk), .rst(rst), .start(start), .busy(busy), .phy_error(phy_error),
		.tx_data(tx_data), .tx_wr_en(tx_wr_en), .tx_full(tx_full),
		.rx_data(rx_data), .rx_rd_en(rx_rd_en), .rx_empty(rx_empty),
		.double_break_start(double_break_start), .double_break_done(double_break_done),
		.device_id(device_id), .id_valid(id_valid), .error_code(error_code)
	);

	updi_device_model #(
		.SEED(85)
	) target_model (
		.clk(clk), .clear(model_clear), .statusa(cfg_statusa), .key_status(cfg_key_status),
		.not_ready_polls(cfg_not_ready), .id_bytes(cfg_id), .silent_attempts(cfg_silent),
		.tx_data(tx_data), .tx_wr_en(tx_wr_en), .tx_full(tx_full),
		.rx_data(rx_data), .rx_rd_en(rx_rd_en), .rx_empty(rx_empty),
		.double_break_start(double_break_start), .double_break_done(double_break_done),
		.break_cnt(break_cnt), .sys_read_cnt(sys_read_cnt)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2;
			clk = ~clk;
		end
	end

	// bytes the TX FIFO accepts, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && tx_wr_en && !tx_full) begin
			tx_seen.push_back(tx_data);
		end
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	initial begin
		cycle_cnt = 0;
		forever begin
			@(posedge clk);
			cycle_cnt = cycle_cnt + 1;
			if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
				stop_run($sformatf("no result within %0d clock cycles", cycle_limit));
			end
		end
	end

	// TX stream the programmer should send for one test line
	task automatic build_expected_stream(input logic [7:0] statusa, input logic [7:0] key_status,
			input int not_ready, input int silent);
		int    i;
		int    attempts;
		string key_text;
		key_text = "NVMProg ";
		exp_tx.delete();
		attempts = (silent > RETRY_LIMIT) ? RETRY_LIMIT + 1 : silent;
		for (i = 0; i < attempts; i++) begin
			exp_tx.push_back(8'h55);
			exp_tx.push_back(8'h80);
		end
		if (silent > RETRY_LIMIT) begin
			return;
		end
		exp_tx.push_back(8'h55);
		exp_tx.push_back(8'h80);
		if (statusa == 8'h00) begin
			return;
		end
		exp_tx.push_back(8'h55);
		exp_tx.push_back(8'hE0);
		// key goes out last character first
		for (i = 0; i < 8; i++) begin
			exp_tx.push_back(key_text[7-i]);
		end
		exp_tx.push_back(8'h55);
		exp_tx.push_back(8'h87);
		if (!key_status[4]) begin
			return;
		end
		exp_tx.push_back(8'h55);
		exp_tx.push_back(8'hC8);
		exp_tx.push_back(8'h59);
		exp_tx.push_back(8'h55);
		exp_tx.push_back(8'hC8);
		exp_tx.push_back(8'h00);
		for (i = 0; i < POLL_LIMIT && i <= not_ready; i++) begin
			exp_tx.push_back(8'h55);
			exp_tx.push_back(8'h8B);
		end
		if (not_ready >= POLL_LIMIT) begin
			return;
		end
		exp_tx.push_back(8'h55);
		exp_tx.push_back(8'h69);
		exp_tx.push_back(8'h00);
		exp_tx.push_back(8'h11);
		exp_tx.push_back(8'h55);
		exp_tx.push_back(8'hA0);
		exp_tx.push_back(8'h02);
		exp_tx.push_back(8'h55);
		exp_tx.push_back(8'h24);
	endtask

	task automatic run_test(input int t);
		int          base;
		int          i;
		int          not_ready;
		int          silent;
		int          exp_err;
		int          exp_breaks;
		int          exp_sys;
		logic        reaches_poll;
		logic [23:0] exp_id;
		base      = 1 + t * REC_W;
		not_ready = int'(tests_mem[base+2]);
		silent    = int'(tests_mem[base+6]);
		exp_err   = int'(tests_mem[base+7]);
		exp_id    = {tests_mem[base+3], tests_mem[base+4], tests_mem[base+5]};

		// set up the target while the DUT is idle
		cfg_statusa    = tests_mem[base];
		cfg_key_status = tests_mem[base+1];
		cfg_not_ready  = tests_mem[base+2];
		cfg_id         = exp_id;
		cfg_silent     = tests_mem[base+6];
		model_clear    = 1'b1;
		tx_seen.delete();
		@(posedge clk);
		#1;
		model_clear = 1'b0;
		start       = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		check_value("busy", 32'(busy), 32'd1);
		while (busy) begin
			@(posedge clk);
			#1;
		end

		reaches_poll = (silent <= RETRY_LIMIT) && (tests_mem[base] != 8'h00)
			&& tests_mem[base+1][4];
		exp_breaks = (silent > RETRY_LIMIT) ? RETRY_LIMIT + 1 : silent + 1;
		exp_sys    = 0;
		if (reaches_poll) begin
			exp_sys = (not_ready < POLL_LIMIT) ? not_ready + 1 : POLL_LIMIT;
		end
		check_value("error_code", 32'(error_code), exp_err);
		check_value("id_valid", 32'(id_valid), (exp_err == 0) ? 32'd1 : 32'd0);
		if (exp_err == 0) begin
			check_value("device_id", 32'(device_id), 32'(exp_id));
		end
		check_value("double_break_start count", 32'(break_cnt), exp_breaks);
		check_value("SYS_STATUS read count", 32'(sys_read_cnt), exp_sys);

		build_expected_stream(tests_mem[base], tests_mem[base+1], not_ready, silent);
		check_value("tx byte count", tx_seen.size(), exp_tx.size());
		for (i = 0; i < exp_tx.size(); i++) begin
			check_value($sformatf("tx_data[%0d]", i), 32'(tx_seen[i]), 32'(exp_tx[i]));
		end
	endtask

	initial begin
		int t;
		rst            = 1'b1;
		start          = 1'b0;
		phy_error      = 1'b0;
		model_clear    = 1'b0;
		cfg_statusa    = 8'h00;
		cfg_key_status = 8'h00;
		cfg_not_ready  = 8'h00;
		cfg_id         = 24'h000000;
		cfg_silent     = 8'h00;
		cycle_limit    = 0;
		$readmemh("bench/updi_tests.txt", tests_mem);
		n_tests = int'(tests_mem[0]);
		if (n_tests < 1 || n_tests > MAX_TESTS) begin
			stop_run("test table does not start with a valid test count");
		end
		cycle_limit = n_tests * (RETRY_LIMIT + 1) * RUN_CLKS;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		for (t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== bench/updi_tests.txt ====
// first word is the number of tests, then one test per line, all values hex:
// statusa key_status not_ready_polls id0 id1 id2 silent_attempts expected_error
0b
30 10 00 1e 95 0f 00 00
82 10 02 1e 93 0b 00 00
00 10 00 1e 95 0f 00 01
30 ef 00 1e 95 0f 00 02
30 10 03 1e 97 0c 00 00
30 10 04 1e 95 0f 00 03
30 10 09 1e 95 0f 00 03
01 3f 00 1e 94 0a 01 00
30 10 01 1e 95 0f 03 00
30 10 00 1e 95 0f 04 04
30 10 00 1e 96 08 06 04

// ==== filelist.f ====
design/updi_pkg.sv
design/updi_tx_framer.sv
design/updi_rx_collector.sv
design/prog_sequencer.sv
design/updi_programmer.sv
bench/updi_device_model.sv
bench/tb_updi_programmer.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the UPDI programmer testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_updi_programmer -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log
if grep -q -x "Simulation completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
